/* Makefile */
VERILATOR   ?= verilator
TOP         := tb_zx_memory_mapper
FILELIST    := filelist.f
BUILD_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only --timing
OBJ_DIR     := obj_dir
LOG         := sim.log
PASS_TEXT   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/zx_mem_pkg.sv */
// ============================================================
// ZX Spectrum memory mapper shared definitions
// Bus widths, physical page numbering and the kinds of bus
// cycle that travel from the decode stage to execution
// ============================================================

`default_nettype none

package zx_mem_pkg;

	// ============================================================
	// Bus and page widths
	// ============================================================

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	// RAM bank n is page n, ROM r is page 40 + r
	typedef logic [6:0] page_t;

	// Offset inside one 16K page
	typedef logic [13:0] offset_t;

	// ============================================================
	// Cycle classification
	// ============================================================

	typedef enum logic [2:0] {
		mem_read,
		mem_write,
		port_7ffd,
		port_1ffd,
		port_fe,
		io_other
	} cycle_kind_t;

	// ============================================================
	// Fixed page numbers
	// ============================================================

	localparam page_t ROM_PAGE_BASE = 7'd40;

	localparam page_t SCREEN_NORMAL_BANK = 7'd5;
	localparam page_t SCREEN_SHADOW_BANK = 7'd7;

	// Banks seen at 4000 and 8000 in the normal map
	localparam page_t FIXED_BANK_SEG1 = 7'd5;
	localparam page_t FIXED_BANK_SEG2 = 7'd2;

endpackage

`default_nettype wire

/* filelist.f */
common/zx_mem_pkg.sv
mapper/cycle_decode.sv
mapper/paging_execute.sv
mapper/page_result.sv
rtl/zx_memory_mapper.sv
tests/tb_zx_memory_mapper.sv

/* mapper/cycle_decode.sv */
// ============================================================
// Mapper decode stage
// Classifies each CPU bus request as a memory cycle or one of
// the paging and ULA port writes, and registers it for the
// execute stage
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module cycle_decode #(
	parameter bit PLUS3 = 1'b0
) (
	input  wire                    clk_sys,
	input  wire                    reset,

	input  wire                    req_valid,
	output logic                   req_ready,
	input  wire                    req_io,
	input  wire                    req_write,
	input  zx_mem_pkg::cpu_addr_t  req_addr,
	input  zx_mem_pkg::cpu_data_t  req_wdata,

	output logic                   dec_valid,
	input  wire                    dec_ready,
	output zx_mem_pkg::cycle_kind_t dec_kind,
	output zx_mem_pkg::cpu_addr_t  dec_addr,
	output zx_mem_pkg::cpu_data_t  dec_data
);

	logic                    hit_7ffd;
	logic                    hit_1ffd;
	logic                    hit_fe;
	zx_mem_pkg::cycle_kind_t kind;

	// Partial port decode of the board
	assign hit_7ffd = ~req_addr[15] & ~req_addr[1] & (req_addr[14] | ~PLUS3);
	assign hit_1ffd = PLUS3 & req_addr[12] & ~req_addr[13] & ~req_addr[14] &
		~req_addr[15] & ~req_addr[1];
	assign hit_fe = ~req_addr[0];

	always_comb begin
		if (!req_io) begin
			kind = req_write ? zx_mem_pkg::mem_write : zx_mem_pkg::mem_read;
		end else if (!req_write) begin
			// I/O reads carry no effect here
			kind = zx_mem_pkg::io_other;
		end else if (hit_7ffd) begin
			kind = zx_mem_pkg::port_7ffd;
		end else if (hit_1ffd) begin
			kind = zx_mem_pkg::port_1ffd;
		end else if (hit_fe) begin
			kind = zx_mem_pkg::port_fe;
		end else begin
			kind = zx_mem_pkg::io_other;
		end
	end

	// One-entry register, refilled when empty or draining
	assign req_ready = ~dec_valid | dec_ready;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else if (req_ready) begin
			dec_valid <= req_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req_valid && req_ready) begin
			dec_kind <= kind;
			dec_addr <= req_addr;
			dec_data <= req_wdata;
		end
	end

endmodule

`default_nettype wire

/* mapper/page_result.sv */
// ============================================================
// Mapper result stage
// Applies ROM write protection and holds one response until
// the consumer takes it
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module page_result (
	input  wire                   clk_sys,
	input  wire                   reset,

	input  wire                   ex_valid,
	output logic                  ex_ready,
	input  zx_mem_pkg::page_t     ex_page,
	input  zx_mem_pkg::offset_t   ex_offset,
	input  wire                   ex_write,
	input  wire                   ex_rom,
	input  zx_mem_pkg::cpu_data_t ex_data,

	output logic                  rsp_valid,
	input  wire                   rsp_ready,
	output zx_mem_pkg::page_t     rsp_page,
	output zx_mem_pkg::offset_t   rsp_offset,
	output logic                  rsp_write,
	output zx_mem_pkg::cpu_data_t rsp_wdata
);

	logic load;

	// Refill when empty or when the held response leaves
	assign ex_ready = ~rsp_valid | rsp_ready;
	assign load     = ex_valid & ex_ready;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else if (ex_ready) begin
			rsp_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load) begin
			rsp_page   <= ex_page;
			rsp_offset <= ex_offset;
			// Writes into ROM pages are dropped
			rsp_write  <= ex_write & ~ex_rom;
			rsp_wdata  <= ex_data;
		end
	end

endmodule

`default_nettype wire

/* mapper/paging_execute.sv */
// ============================================================
// Mapper execute stage
// Holds the 7FFD and 1FFD paging registers and the ULA latch,
// consumes port writes and turns each memory cycle into a
// physical page and offset
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module paging_execute #(
	parameter bit PLUS3 = 1'b0
) (
	input  wire                     clk_sys,
	input  wire                     reset,

	input  wire                     dec_valid,
	output logic                    dec_ready,
	input  zx_mem_pkg::cycle_kind_t dec_kind,
	input  zx_mem_pkg::cpu_addr_t   dec_addr,
	input  zx_mem_pkg::cpu_data_t   dec_data,

	output logic                    ex_valid,
	input  wire                     ex_ready,
	output zx_mem_pkg::page_t       ex_page,
	output zx_mem_pkg::offset_t     ex_offset,
	output logic                    ex_write,
	output logic                    ex_rom,
	output zx_mem_pkg::cpu_data_t   ex_data,

	output logic [2:0]              border,
	output logic                    ear,
	output logic                    mic
	,
	output zx_mem_pkg::page_t       screen_bank
);

	// 7FFD bits 5..0 and 1FFD bits 2..0 are all the map needs
	logic [5:0]        reg_7ffd;
	logic [2:0]        reg_1ffd;
	logic              locked;
	logic              special;
	logic              accept;
	logic              is_mem;
	logic [1:0]        seg;
	logic [2:0]        rom_num;
	logic [2:0]        bank;
	logic              rom_hit;
	zx_mem_pkg::page_t page;

	assign locked  = reg_7ffd[5];
	assign special = PLUS3 & reg_1ffd[0];
	assign seg     = dec_addr[15:14];

	assign accept = dec_valid & dec_ready;
	assign is_mem = (dec_kind == zx_mem_pkg::mem_read) ||
		(dec_kind == zx_mem_pkg::mem_write);

	assign dec_ready = ~ex_valid | ex_ready;

	// ============================================================
	// Page resolution
	// ============================================================

	assign rom_num = PLUS3 ? {1'b0, reg_1ffd[2], reg_7ffd[4]} : {2'b11, reg_7ffd[4]};

	always_comb begin
		bank    = 3'd0;
		rom_hit = 1'b0;
		if (special) begin
			// All-RAM configurations picked by 1FFD bits 2..1
			case (reg_1ffd[2:1])
				2'd0:    bank = {1'b0, seg};
				2'd1:    bank = {1'b1, seg};
				2'd2:    bank = (seg == 2'd3) ? 3'd3 : {1'b1, seg};
				default: begin
					case (seg)
						2'd0:    bank = 3'd4;
						2'd1:    bank = 3'd7;
						2'd2:    bank = 3'd6;
						default: bank = 3'd3;
					endcase
				end
			endcase
			page = zx_mem_pkg::page_t'(bank);
		end else begin
			case (seg)
				2'd0: begin
					rom_hit = 1'b1;
					page    = zx_mem_pkg::ROM_PAGE_BASE + zx_mem_pkg::page_t'(rom_num);
				end
				2'd1:    page = zx_mem_pkg::FIXED_BANK_SEG1;
				2'd2:    page = zx_mem_pkg::FIXED_BANK_SEG2;
				default: page = zx_mem_pkg::page_t'(reg_7ffd[2:0]);
			endcase
		end
	end

	// ============================================================
	// Paging registers and ULA latch
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_7ffd <= '0;
			reg_1ffd <= '0;
			border   <= '0;
			ear      <= 1'b0;
			mic      <= 1'b0;
		end else if (accept) begin
			if (dec_kind == zx_mem_pkg::port_7ffd && !locked) begin
				reg_7ffd <= dec_data[5:0];
			end
			if (dec_kind == zx_mem_pkg::port_1ffd && !locked) begin
				reg_1ffd <= dec_data[2:0];
			end
			if (dec_kind == zx_mem_pkg::port_fe) begin
				border <= dec_data[2:0];
				ear    <= dec_data[4];
				mic    <= dec_data[3];
			end
		end
	end

	assign screen_bank = reg_7ffd[3] ? zx_mem_pkg::SCREEN_SHADOW_BANK :
		zx_mem_pkg::SCREEN_NORMAL_BANK;

	// Only memory cycles move on
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else if (accept) begin
			ex_valid <= is_mem;
		end else if (ex_ready) begin
			ex_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept && is_mem) begin
			ex_page   <= page;
			ex_offset <= dec_addr[13:0];
			ex_write  <= (dec_kind == zx_mem_pkg::mem_write);
			ex_rom    <= rom_hit;
			ex_data   <= dec_data;
		end
	end

endmodule

`default_nettype wire

/* rtl/zx_memory_mapper.sv */
// ============================================================
// ZX Spectrum memory mapper
// Three-stage pipeline: decode, paging execute and result.
// PLUS3 selects 128K or +3 paging behaviour
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module zx_memory_mapper #(
	parameter bit PLUS3 = 1'b0
) (
	input  wire                   clk_sys,
	input  wire                   reset,

	input  wire                   req_valid,
	output logic                  req_ready,
	input  wire                   req_io,
	input  wire                   req_write,
	input  zx_mem_pkg::cpu_addr_t req_addr,
	input  zx_mem_pkg::cpu_data_t req_wdata,

	output logic                  rsp_valid,
	input  wire                   rsp_ready,
	output zx_mem_pkg::page_t     rsp_page,
	output zx_mem_pkg::offset_t   rsp_offset,
	output logic                  rsp_write,
	output zx_mem_pkg::cpu_data_t rsp_wdata,

	output logic [2:0]            border,
	output logic                  ear,
	output logic                  mic,
	output zx_mem_pkg::page_t     screen_bank
);

	// Decode to execute
	logic                    dec_valid;
	logic                    dec_ready;
	zx_mem_pkg::cycle_kind_t dec_kind;
	zx_mem_pkg::cpu_addr_t   dec_addr;
	zx_mem_pkg::cpu_data_t   dec_data;

	// Execute to result
	logic                    ex_valid;
	logic                    ex_ready;
	zx_mem_pkg::page_t       ex_page;
	zx_mem_pkg::offset_t     ex_offset;
	logic                    ex_write;
	logic                    ex_rom;
	zx_mem_pkg::cpu_data_t   ex_data;

	cycle_decode #(
		.PLUS3 (PLUS3)
	) i_cycle_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_io    (req_io),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.dec_kind  (dec_kind),
		.dec_addr  (dec_addr),
		.dec_data  (dec_data)
	);

	paging_execute #(
		.PLUS3 (PLUS3)
	) i_paging_execute (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dec_valid   (dec_valid),
		.dec_ready   (dec_ready),
		.dec_kind    (dec_kind),
		.dec_addr    (dec_addr),
		.dec_data    (dec_data),
		.ex_valid    (ex_valid),
		.ex_ready    (ex_ready),
		.ex_page     (ex_page),
		.ex_offset   (ex_offset),
		.ex_write    (ex_write),
		.ex_rom      (ex_rom),
		.ex_data     (ex_data),
		.border      (border),
		.ear         (ear),
		.mic         (mic),
		.screen_bank (screen_bank)
	);

	page_result i_page_result (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ex_valid   (ex_valid),
		.ex_ready   (ex_ready),
		.ex_page    (ex_page),
		.ex_offset  (ex_offset),
		.ex_write   (ex_write),
		.ex_rom     (ex_rom),
		.ex_data    (ex_data),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.rsp_page   (rsp_page),
		.rsp_offset (rsp_offset),
		.rsp_write  (rsp_write),
		.rsp_wdata  (rsp_wdata)
	);

endmodule

`default_nettype wire

/* tests/tb_zx_memory_mapper.sv */
// ============================================================
// Testbench for the ZX Spectrum memory mapper
// Directed tests for 7FFD and 1FFD paging, the lock bit, the
// ULA latch, ROM write protection and response back-pressure
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module tb_zx_memory_mapper;

	localparam int TIMEOUT_CYCLES = 4000;

	logic                  clk_sys;
	logic                  reset;
	logic                  req_valid;
	logic                  req_ready;
	logic                  req_io;
	logic                  req_write;
	zx_mem_pkg::cpu_addr_t req_addr;
	zx_mem_pkg::cpu_data_t req_wdata;
	logic                  rsp_valid;
	logic                  rsp_ready = 1'b1;
	zx_mem_pkg::page_t     rsp_page;
	zx_mem_pkg::offset_t   rsp_offset;
	logic                  rsp_write;
	zx_mem_pkg::cpu_data_t rsp_wdata;
	logic [2:0]            border;
	logic                  ear;
	logic                  mic;
	zx_mem_pkg::page_t     screen_bank;

	int   error_count = 0;
	int   check_count = 0;
	int   cycle_count = 0;
	int   stretch = 0;
	logic bp_enable = 1'b0;

	// Reference copies of the port registers
	logic [7:0] m_7ffd;
	logic [7:0] m_1ffd;
	logic [7:0] m_fe;

	int exp_page[$];
	int exp_offset[$];
	int exp_write[$];
	int exp_wdata[$];
	int got_page[$];
	int got_offset[$];
	int got_write[$];
	int got_wdata[$];

	zx_memory_mapper #(
		.PLUS3 (1'b1)
	) i_zx_memory_mapper (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_io      (req_io),
		.req_write   (req_write),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp_page    (rsp_page),
		.rsp_offset  (rsp_offset),
		.rsp_write   (rsp_write),
		.rsp_wdata   (rsp_wdata),
		.border      (border),
		.ear         (ear),
		.mic         (mic),
		.screen_bank (screen_bank)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Monitors, back-pressure and timeout
	// ============================================================

	always @(posedge clk_sys) begin
		if (!reset && rsp_valid && rsp_ready) begin
			got_page.push_back(int'(rsp_page));
			got_offset.push_back(int'(rsp_offset));
			got_write.push_back(int'(rsp_write));
			got_wdata.push_back(int'(rsp_wdata));
		end
	end

	// Random stretches of rsp_ready low while enabled
	always @(posedge clk_sys) begin
		#2;
		if (!bp_enable) begin
			rsp_ready = 1'b1;
		end else if (stretch == 0) begin
			rsp_ready = ($urandom % 2) == 0;
			stretch = 1 + int'($urandom % 6);
		end else begin
			stretch = stretch - 1;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks run %0d, errors %0d", check_count, error_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	task automatic check_value(input string name, input int got, input int exp);
		check_count = check_count + 1;
		assert (got == exp) else begin
			error_count = error_count + 1;
			$display("error: time %0t, %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	function automatic int expected_page(input logic [15:0] addr);
		logic [1:0]  seg;
		logic [11:0] banks;
		int          page;
		seg = addr[15:14];
		if (m_1ffd[0]) begin
			// Banks packed as {seg3, seg2, seg1, seg0}
			case (m_1ffd[2:1])
				2'd0:    banks = {3'd3, 3'd2, 3'd1, 3'd0};
				2'd1:    banks = {3'd7, 3'd6, 3'd5, 3'd4};
				2'd2:    banks = {3'd3, 3'd6, 3'd5, 3'd4};
				default: banks = {3'd3, 3'd6, 3'd7, 3'd4};
			endcase
			page = int'(banks[int'(seg) * 3 +: 3]);
		end else begin
			case (seg)
				2'd0:    page = 40 + int'({m_1ffd[2], m_7ffd[4]});
				2'd1:    page = 5;
				2'd2:    page = 2;
				default: page = int'(m_7ffd[2:0]);
			endcase
		end
		return page;
	endfunction

	// Entered and left 2 ns after a rising edge
	task automatic send_req(input logic io, input logic wr, input logic [15:0] addr,
		input logic [7:0] data);
		logic taken;
		taken     = 1'b0;
		req_valid = 1'b1;
		req_io    = io;
		req_write = wr;
		req_addr  = addr;
		req_wdata = data;
		while (!taken) begin
			#1;
			taken = req_ready;
			@(posedge clk_sys);
			#2;
		end
		req_valid = 1'b0;
	endtask

	task automatic read_mem(input logic [15:0] addr);
		exp_page.push_back(expected_page(addr));
		exp_offset.push_back(int'(addr[13:0]));
		exp_write.push_back(0);
		exp_wdata.push_back(0);
		send_req(1'b0, 1'b0, addr, 8'h00);
	endtask

	task automatic write_mem(input logic [15:0] addr, input logic [7:0] data);
		logic rom;
		rom = !m_1ffd[0] && (addr[15:14] == 2'd0);
		exp_page.push_back(expected_page(addr));
		exp_offset.push_back(int'(addr[13:0]));
		exp_write.push_back(rom ? 0 : 1);
		exp_wdata.push_back(int'(data));
		send_req(1'b0, 1'b1, addr, data);
	endtask

	task automatic write_port(input logic [15:0] port, input logic [7:0] data);
		// Lock bit freezes both paging registers
		if (port == 16'h7ffd && !m_7ffd[5]) begin
			m_7ffd = data;
		end else if (port == 16'h1ffd && !m_7ffd[5]) begin
			m_1ffd = data;
		end else if (port == 16'h00fe) begin
			m_fe = data;
		end
		send_req(1'b1, 1'b1, port, data);
	endtask

	task automatic clear_queues();
		exp_page.delete();
		exp_offset.delete();
		exp_write.delete();
		exp_wdata.delete();
		got_page.delete();
		got_offset.delete();
		got_write.delete();
		got_wdata.delete();
	endtask

	task automatic apply_reset();
		reset     = 1'b1;
		req_valid = 1'b0;
		bp_enable = 1'b0;
		wait_cycles(2);
		reset  = 1'b0;
		m_7ffd = 8'h00;
		m_1ffd = 8'h00;
		m_fe   = 8'h00;
		clear_queues();
	endtask

	task automatic drain_and_compare();
		int n;
		int i;
		while (got_page.size() < exp_page.size()) begin
			wait_cycles(1);
		end
		// A few more cycles so that a stray response shows up
		wait_cycles(4);
		check_value("response count", got_page.size(), exp_page.size());
		n = (got_page.size() < exp_page.size()) ? got_page.size() : exp_page.size();
		for (i = 0; i < n; i++) begin
			check_value("rsp_page", got_page[i], exp_page[i]);
			check_value("rsp_offset", got_offset[i], exp_offset[i]);
			check_value("rsp_write", got_write[i], exp_write[i]);
			check_value("rsp_wdata", got_wdata[i], exp_wdata[i]);
		end
		clear_queues();
	endtask

	task automatic check_status();
		check_value("border", int'(border), int'(m_fe[2:0]));
		check_value("ear", int'(ear), int'(m_fe[4]));
		check_value("mic", int'(mic), int'(m_fe[3]));
		check_value("screen_bank", int'(screen_bank), m_7ffd[3] ? 7 : 5);
	endtask

	// ============================================================
	// Directed tests
	// ============================================================

	task automatic test_reset_map();
		apply_reset();
		check_value("req_ready", int'(req_ready), 1);
		check_value("rsp_valid", int'(rsp_valid), 0);
		read_mem(16'h0000);
		read_mem(16'h4000);
		read_mem(16'h8000);
		read_mem(16'hc000);
		drain_and_compare();
		check_status();
	endtask

	task automatic test_7ffd_paging();
		int         idx;
		logic [2:0] bank;
		for (idx = 0; idx < 8; idx++) begin
			bank = 3'(idx);
			// Bit 4 and bit 3 toggle with the bank value
			write_port(16'h7ffd, {3'b000, bank[0], bank[1], bank});
			read_mem({2'b11, 8'h0, bank, 3'h5});
			read_mem(16'h0123);
			write_mem(16'hc3a0, {5'h0, bank});
			drain_and_compare();
			check_status();
		end
	endtask

	task automatic test_lock();
		write_port(16'h7ffd, 8'h23);
		write_port(16'h7ffd, 8'h14);
		write_port(16'h1ffd, 8'h01);
		read_mem(16'hc010);
		read_mem(16'h0010);
		read_mem(16'h4010);
		drain_and_compare();
		check_status();
		apply_reset();
		write_port(16'h7ffd, 8'h16);
		read_mem(16'hc020);
		read_mem(16'h0020);
		drain_and_compare();
		check_status();
	endtask

	task automatic test_special();
		int         cfg;
		int         seg;
		logic [1:0] sel;
		for (cfg = 0; cfg < 4; cfg++) begin
			sel = 2'(cfg);
			write_port(16'h1ffd, {5'b00000, sel, 1'b1});
			for (seg = 0; seg < 4; seg++) begin
				read_mem({2'(seg), 14'h0155});
			end
			write_mem(16'h0042, 8'h5a);
			drain_and_compare();
		end
	endtask

	task automatic test_ula_and_protect();
		write_port(16'h1ffd, 8'h00);
		write_port(16'h00fe, 8'h15);
		drain_and_compare();
		check_status();
		write_port(16'h00fe, 8'h0a);
		write_mem(16'h1234, 8'haa);
		// I/O reads are swallowed and leave the map alone
		send_req(1'b1, 1'b0, 16'h7ffd, 8'h07);
		send_req(1'b1, 1'b0, 16'h00fe, 8'h1f);
		read_mem(16'hc001);
		drain_and_compare();
		check_status();
	endtask

	task automatic test_backpressure();
		int          k;
		logic [15:0] addr;
		logic [7:0]  data;
		bp_enable = 1'b1;
		for (k = 0; k < 60; k++) begin
			addr = 16'($urandom);
			data = 8'($urandom);
			if (k % 15 == 7) begin
				write_port(16'h7ffd, data & 8'h1f);
			end else if ($urandom % 2 == 0) begin
				read_mem(addr);
			end else begin
				write_mem(addr, data);
			end
			if ($urandom % 4 == 0) begin
				wait_cycles(1);
			end
		end
		drain_and_compare();
		bp_enable = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h8ab9));
		reset     = 1'b1;
		req_valid = 1'b0;
		req_io    = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		test_reset_map();
		test_7ffd_paging();
		test_lock();
		test_special();
		test_ula_and_protect();
		test_backpressure();
		$display("Checks run %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
